//--- rtl/stream_pkg.sv
// stream word width and the data word type

`default_nettype none

package stream_pkg;

	// ----------------------------------------------------------
	// stream word
	// ----------------------------------------------------------

	// bits per word on both ports
	localparam int DATA_WIDTH = 8;

	// one word as carried through RAM, read stage and ports
	typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

//--- rtl/fifo_geom_pkg.sv
// buffer geometry: pointer width, depth, register defaults, pointer and count types

`default_nettype none

package fifo_geom_pkg;

	// ----------------------------------------------------------
	// buffer geometry
	// ----------------------------------------------------------

	localparam int PTR_WIDTH = 4;
	localparam int DEPTH     = 1 << PTR_WIDTH;

	// pipeline register defaults
	localparam int DOUT_REGS_DEFAULT   = 1;
	localparam int MASTER_REGS_DEFAULT = 1;

	// RAM address
	typedef logic [PTR_WIDTH-1:0] ptr_t;

	// one bit wider, so a full buffer of DEPTH words can be counted
	typedef logic [PTR_WIDTH:0] count_t;

endpackage

`default_nettype wire

//--- rtl/fifo_rd_if.sv
// read port interface between storage and read stage, storage and reader modports

`timescale 1ns/1ps
`default_nettype none

interface fifo_rd_if;
	import stream_pkg::*;
	import fifo_geom_pkg::*;

	// pop request, one word per edge where high
	logic   rd_en;

	// clock enable of the RAM output register
	logic   rd_regcke;

	// read word, valid 1 + DOUT_REGS cycles after rd_en
	data_t  rd_data;

	// registered status of the storage
	logic   empty;
	count_t data_count;

	modport storage (
		input  rd_en,
		input  rd_regcke,
		output rd_data,
		output empty,
		output data_count
	);

	modport reader (
		output rd_en,
		output rd_regcke,
		input  rd_data,
		input  empty,
		input  data_count
	);

endinterface

`default_nettype wire

//--- rtl/fifo_ram.sv
// simple dual-port RAM with synchronous read and optional output register

`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
	parameter int DOUT_REGS = fifo_geom_pkg::DOUT_REGS_DEFAULT
) (
	input  wire                     clk,

	// write port
	input  wire                     wr_en,
	input  wire fifo_geom_pkg::ptr_t wr_addr,
	input  wire stream_pkg::data_t  wr_data,

	// read port
	input  wire                     rd_en,
	input  wire                     rd_regcke,
	input  wire fifo_geom_pkg::ptr_t rd_addr,
	output stream_pkg::data_t       rd_data
);
	import stream_pkg::*;
	import fifo_geom_pkg::*;

	data_t mem [DEPTH];
	data_t rd_q;

	// ----------------------------------------------------------
	// array
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// first read stage, loads only on a pop
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_q <= mem[rd_addr];
		end
	end

	// ----------------------------------------------------------
	// output register
	// ----------------------------------------------------------

	generate
		if (DOUT_REGS != 0) begin : g_dout_reg
			data_t dout_q;

			always_ff @(posedge clk) begin
				if (rd_regcke) begin
					dout_q <= rd_q;
				end
			end

			assign rd_data = dout_q;
		end else begin : g_no_dout_reg
			assign rd_data = rd_q;
		end
	endgenerate

endmodule

`default_nettype wire

//--- rtl/fifo_core.sv
// fifo storage core: write accept, wrap-bit pointers, flags, occupancy counts, RAM instance

`timescale 1ns/1ps
`default_nettype none

module fifo_core #(
	parameter int DOUT_REGS = fifo_geom_pkg::DOUT_REGS_DEFAULT
) (
	input  wire                      clk,
	input  wire                      arst_n,

	// slave side
	input  wire stream_pkg::data_t   s_data,
	input  wire                      s_valid,
	output logic                     s_ready,
	output fifo_geom_pkg::count_t    s_free_count,

	// read port towards the read stage
	fifo_rd_if.storage               rd
);
	import fifo_geom_pkg::*;

	// pointers with a wrap bit above the address bits
	count_t wr_ptr_q;
	count_t rd_ptr_q;
	count_t wr_ptr_d;
	count_t rd_ptr_d;

	// registered status
	logic   full_q;
	logic   empty_q;
	count_t count_q;
	count_t free_q;

	logic   full_d;
	logic   empty_d;
	count_t count_d;

	logic   wr_do;
	logic   rd_do;

	// ----------------------------------------------------------
	// accept and pop
	// ----------------------------------------------------------

	assign wr_do = s_valid & ~full_q;

	// guard the pop, the reader should never ask while empty
	assign rd_do = rd.rd_en & ~empty_q;

	assign wr_ptr_d = wr_ptr_q + count_t'(wr_do);
	assign rd_ptr_d = rd_ptr_q + count_t'(rd_do);

	// same address, wrap bits differ -> full
	assign full_d  = (wr_ptr_d[PTR_WIDTH] != rd_ptr_d[PTR_WIDTH]) &&
	                 (wr_ptr_d[PTR_WIDTH-1:0] == rd_ptr_d[PTR_WIDTH-1:0]);
	assign empty_d = (wr_ptr_d == rd_ptr_d);
	assign count_d = wr_ptr_d - rd_ptr_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			full_q   <= 1'b0;
			empty_q  <= 1'b1;
			count_q  <= '0;
			free_q   <= count_t'(DEPTH);
		end else begin
			wr_ptr_q <= wr_ptr_d;
			rd_ptr_q <= rd_ptr_d;
			full_q   <= full_d;
			empty_q  <= empty_d;
			count_q  <= count_d;
			free_q   <= count_t'(DEPTH) - count_d;
		end
	end

	// ----------------------------------------------------------
	// outputs
	// ----------------------------------------------------------

	assign s_ready      = ~full_q;
	assign s_free_count = free_q;

	assign rd.empty      = empty_q;
	assign rd.data_count = count_q;

	fifo_ram #(
		.DOUT_REGS (DOUT_REGS)
	) u_ram (
		.clk       (clk),
		.wr_en     (wr_do),
		.wr_addr   (ptr_t'(wr_ptr_q[PTR_WIDTH-1:0])),
		.wr_data   (s_data),
		.rd_en     (rd_do),
		.rd_regcke (rd.rd_regcke),
		.rd_addr   (ptr_t'(rd_ptr_q[PTR_WIDTH-1:0])),
		.rd_data   (rd.rd_data)
	);

endmodule

`default_nettype wire

//--- rtl/fifo_read_fwft.sv
// fall-through read stage: credit counter, latency valid line, skid buffer, master register

`timescale 1ns/1ps
`default_nettype none

module fifo_read_fwft #(
	parameter int DOUT_REGS   = fifo_geom_pkg::DOUT_REGS_DEFAULT,
	parameter int MASTER_REGS = fifo_geom_pkg::MASTER_REGS_DEFAULT
) (
	input  wire                   clk,
	input  wire                   arst_n,

	fifo_rd_if.reader             rd,

	// master side
	output stream_pkg::data_t     m_data,
	output logic                  m_valid,
	input  wire                   m_ready,
	output fifo_geom_pkg::count_t m_data_count
);
	import stream_pkg::*;
	import fifo_geom_pkg::*;

	localparam int LAT         = 1 + DOUT_REGS;
	localparam int STAGE_SLOTS = 1 + DOUT_REGS + MASTER_REGS;
	localparam int SKID_DEPTH  = 1 + DOUT_REGS;
	localparam int SKID_CW     = $clog2(SKID_DEPTH + 1);

	count_t             hold_cnt;
	logic               xfer;
	logic [LAT-1:0]     vld_sr;
	logic               arrive;

	data_t              skid_q [SKID_DEPTH];
	logic [SKID_CW-1:0] skid_cnt;
	logic               skid_push;
	logic               skid_pop;
	int                 skid_wr_idx;

	// ----------------------------------------------------------
	// credits and RAM read requests
	// ----------------------------------------------------------

	assign xfer = m_valid & m_ready;

	// a transfer in this cycle frees its slot for a new read
	assign rd.rd_en = ~rd.empty & ((hold_cnt < count_t'(STAGE_SLOTS)) | xfer);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hold_cnt <= '0;
			vld_sr   <= '0;
		end else begin
			hold_cnt <= hold_cnt + count_t'(rd.rd_en) - count_t'(xfer);
			vld_sr   <= LAT'({vld_sr, rd.rd_en});
		end
	end

	// first stage valid moves data into the RAM output register
	assign rd.rd_regcke = vld_sr[0];
	assign arrive       = vld_sr[LAT-1];

	assign m_data_count = rd.data_count + hold_cnt;

	// ----------------------------------------------------------
	// skid buffer, head at index 0
	// ----------------------------------------------------------

	always_comb begin
		skid_wr_idx = int'(skid_cnt) - int'(skid_pop);
	end

	always_ff @(posedge clk) begin
		if (skid_pop) begin
			for (int i = 0; i < SKID_DEPTH - 1; i++) begin
				skid_q[i] <= skid_q[i+1];
			end
		end
		if (skid_push) begin
			skid_q[skid_wr_idx] <= rd.rd_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			skid_cnt <= '0;
		end else begin
			skid_cnt <= skid_cnt + SKID_CW'(skid_push) - SKID_CW'(skid_pop);
		end
	end

	// ----------------------------------------------------------
	// master port
	// ----------------------------------------------------------

	generate
		if (MASTER_REGS != 0) begin : g_master_reg
			typedef enum logic [1:0] {
				ST_EMPTY,
				ST_LOAD,
				ST_HOLD
			} rd_state_t;

			rd_state_t state_q;
			rd_state_t state_d;
			data_t     out_q;
			logic      src_valid;
			data_t     src_data;
			logic      load;

			// skid head first, else the word returning from RAM
			assign src_valid = (skid_cnt != '0) | arrive;
			assign src_data  = (skid_cnt != '0) ? skid_q[0] : rd.rd_data;
			assign load      = src_valid & ((state_q == ST_EMPTY) | m_ready);

			assign skid_pop  = load & (skid_cnt != '0);
			assign skid_push = arrive & ~(load & (skid_cnt == '0));

			always_comb begin
				state_d = state_q;
				case (state_q)
					ST_EMPTY: begin
						if (src_valid) begin
							state_d = ST_LOAD;
						end
					end
					ST_LOAD, ST_HOLD: begin
						if (!m_ready) begin
							state_d = ST_HOLD;
						end else if (src_valid) begin
							state_d = ST_LOAD;
						end else begin
							state_d = ST_EMPTY;
						end
					end
					default: state_d = ST_EMPTY;
				endcase
			end

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					state_q <= ST_EMPTY;
				end else begin
					state_q <= state_d;
				end
			end

			always_ff @(posedge clk) begin
				if (load) begin
					out_q <= src_data;
				end
			end

			assign m_valid = (state_q != ST_EMPTY);
			assign m_data  = out_q;
		end else begin : g_no_master_reg
			// skid head drives the port directly
			assign skid_push = arrive;
			assign skid_pop  = xfer;
			assign m_valid   = (skid_cnt != '0);
			assign m_data    = skid_q[0];
		end
	endgenerate

endmodule

`default_nettype wire

//--- rtl/fifo_fwft.sv
// fall-through stream fifo top level with slave and master ports

`timescale 1ns/1ps
`default_nettype none

module fifo_fwft (
	input  wire                   clk,
	input  wire                   arst_n,

	// slave
	input  wire stream_pkg::data_t s_data,
	input  wire                   s_valid,
	output logic                  s_ready,
	output fifo_geom_pkg::count_t s_free_count,

	// master
	output stream_pkg::data_t     m_data,
	output logic                  m_valid,
	input  wire                   m_ready,
	output fifo_geom_pkg::count_t m_data_count
);
	import fifo_geom_pkg::*;

	fifo_rd_if u_rd_if ();

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------

	fifo_core #(
		.DOUT_REGS    (DOUT_REGS_DEFAULT)
	) u_core (
		.clk          (clk),
		.arst_n       (arst_n),
		.s_data       (s_data),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.s_free_count (s_free_count),
		.rd           (u_rd_if.storage)
	);

	// ----------------------------------------------------------
	// read stage
	// ----------------------------------------------------------

	fifo_read_fwft #(
		.DOUT_REGS    (DOUT_REGS_DEFAULT),
		.MASTER_REGS  (MASTER_REGS_DEFAULT)
	) u_read (
		.clk          (clk),
		.arst_n       (arst_n),
		.rd           (u_rd_if.reader),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.m_data_count (m_data_count)
	);

endmodule

`default_nettype wire

//--- verif/fifo_fwft_chk.sv
// bound checker with master handshake, occupancy and count bound assertions

`timescale 1ns/1ps
`default_nettype none

module fifo_fwft_chk (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        s_valid,
	input  wire                        s_ready,
	input  wire fifo_geom_pkg::count_t s_free_count,
	input  wire stream_pkg::data_t     m_data,
	input  wire                        m_valid,
	input  wire                        m_ready,
	input  wire fifo_geom_pkg::count_t m_data_count,
	input  wire                        rd_en
);
	import fifo_geom_pkg::*;

	localparam int STAGE_SLOTS = 1 + DOUT_REGS_DEFAULT + MASTER_REGS_DEFAULT;

	// failures seen so far
	int assert_fails = 0;

	// words in the RAM, counted from accepted writes and pops
	int used;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			used <= 0;
		end else begin
			used <= used + int'(s_valid && s_ready) - int'(rd_en);
		end
	end

	// ----------------------------------------------------------
	// master handshake
	// ----------------------------------------------------------

	m_data_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		(m_valid && !m_ready) |=> $stable(m_data)
	) else begin
		assert_fails++;
		$error("m_data changed while the master port was stalled");
	end

	m_valid_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		(m_valid && !m_ready) |=> m_valid
	) else begin
		assert_fails++;
		$error("m_valid dropped before its transfer");
	end

	// ----------------------------------------------------------
	// counts
	// ----------------------------------------------------------

	free_plus_used: assert property (
		@(posedge clk) disable iff (!arst_n)
		(int'(s_free_count) + used) == DEPTH
	) else begin
		assert_fails++;
		$error("s_free_count plus core occupancy differs from the depth");
	end

	count_bound: assert property (
		@(posedge clk) disable iff (!arst_n)
		int'(m_data_count) <= DEPTH + STAGE_SLOTS
	) else begin
		assert_fails++;
		$error("m_data_count above the buffer capacity");
	end

endmodule

bind fifo_fwft fifo_fwft_chk u_chk (
	.clk          (clk),
	.arst_n       (arst_n),
	.s_valid      (s_valid),
	.s_ready      (s_ready),
	.s_free_count (s_free_count),
	.m_data       (m_data),
	.m_valid      (m_valid),
	.m_ready      (m_ready),
	.m_data_count (m_data_count),
	.rd_en        (u_rd_if.rd_en)
);

`default_nettype wire

//--- verif/fifo_fwft_tb.sv
// fall-through fifo testbench with clock, reset, stimulus table, reference queue, checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module fifo_fwft_tb;
	import stream_pkg::*;
	import fifo_geom_pkg::*;

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int STAGE_SLOTS   = 1 + DOUT_REGS_DEFAULT + MASTER_REGS_DEFAULT;
	localparam int SETTLE_CYCLES = 16;
	localparam int NUM_ROWS      = 4;

	typedef struct {
		string name;
		int    words;
		int    wr_pct;
		int    rd_pct;
	} row_t;

	logic   clk;
	logic   arst_n;
	data_t  s_data;
	logic   s_valid;
	logic   s_ready;
	count_t s_free_count;
	data_t  m_data;
	logic   m_valid;
	logic   m_ready;
	count_t m_data_count;

	// name, words to write, write-valid %, read-ready %
	row_t rows [NUM_ROWS] = '{
		'{"full_rate_stream", 64, 100, 100},
		'{"fill_stalled", DEPTH + STAGE_SLOTS, 100, 0},
		'{"random_50_30", 80, 50, 30},
		'{"random_30_70", 80, 30, 70}
	};

	data_t ref_q [$];
	string cur_name = "reset";
	logic  wr_fire = 1'b0;
	int    errors = 0;

	fifo_fwft u_fifo_fwft (
		.clk          (clk),
		.arst_n       (arst_n),
		.s_data       (s_data),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.s_free_count (s_free_count),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.m_data_count (m_data_count)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// reference queue sampled mid-cycle where the inputs are stable
	always @(negedge clk) begin
		wr_fire = arst_n && s_valid && s_ready;
		if (arst_n && m_valid && m_ready) begin
			if (ref_q.size() == 0) begin
				errors++;
				$display("%s: word left the master port with nothing left to expect", cur_name);
			end else begin
				check_data(cur_name, ref_q[0], m_data);
				void'(ref_q.pop_front());
			end
		end
		if (wr_fire) begin
			ref_q.push_back(s_data);
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------

	task automatic run_row(input row_t row);
		int sent;
		sent = 0;
		cur_name = row.name;
		while (sent < row.words) begin
			@(posedge clk);
			if (wr_fire) begin
				sent++;
			end
			// hold a pending word until it is taken
			if (sent >= row.words) begin
				s_valid <= 1'b0;
			end else if (!s_valid || wr_fire) begin
				s_valid <= (($urandom % 100) < row.wr_pct);
				s_data  <= data_t'($urandom);
			end
			m_ready <= (($urandom % 100) < row.rd_pct);
		end
		m_ready <= 1'b0;
	endtask

	// an idle fifo keeps up to STAGE_SLOTS words in the stage and the rest in RAM
	task automatic settle_and_check(input string name);
		int q;
		int core_exp;
		int waited;
		@(negedge clk);
		q = ref_q.size();
		core_exp = (q > STAGE_SLOTS) ? q - STAGE_SLOTS : 0;
		waited = 0;
		while ((m_data_count != count_t'(q) || s_free_count != count_t'(DEPTH - core_exp) ||
		        m_valid != (q != 0)) && waited < SETTLE_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		check_count({name, " m_data_count"}, count_t'(q), m_data_count);
		check_count({name, " s_free_count"}, count_t'(DEPTH - core_exp), s_free_count);
		check_flag({name, " s_ready"}, core_exp < DEPTH, s_ready);
		check_flag({name, " m_valid"}, q != 0, m_valid);
	endtask

	task automatic drain(input string name);
		cur_name = name;
		while (ref_q.size() != 0) begin
			@(posedge clk);
			m_ready <= 1'b1;
		end
		@(posedge clk);
		m_ready <= 1'b0;
		settle_and_check({name, " drained"});
	endtask

	// ----------------------------------------------------------
	// main sequence and verdict
	// ----------------------------------------------------------

	initial begin
		int fails;
		void'($urandom(53));
		arst_n  = 1'b0;
		s_data  = '0;
		s_valid = 1'b0;
		m_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);

		check_flag("reset m_valid", 1'b0, m_valid);
		check_flag("reset s_ready", 1'b1, s_ready);
		check_count("reset m_data_count", '0, m_data_count);
		check_count("reset s_free_count", count_t'(DEPTH), s_free_count);

		foreach (rows[i]) begin
			run_row(rows[i]);
			settle_and_check(rows[i].name);
			drain(rows[i].name);
		end

		fails = u_fifo_fwft.u_chk.assert_fails;
		$display("errors: %0d check, %0d assertion", errors, fails);
		if (errors == 0 && fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// run limit from the table length
	initial begin
		int limit_cycles;
		limit_cycles = 100;
		foreach (rows[i]) begin
			limit_cycles += rows[i].words * 40;
		end
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: run still busy after %0d cycles in %s", limit_cycles, cur_name);
		$display("errors: %0d check, %0d assertion", errors, u_fifo_fwft.u_chk.assert_fails);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/stream_pkg.sv
rtl/fifo_geom_pkg.sv
rtl/fifo_rd_if.sv
rtl/fifo_ram.sv
rtl/fifo_core.sv
rtl/fifo_read_fwft.sv
rtl/fifo_fwft.sv
verif/fifo_fwft_chk.sv
verif/fifo_fwft_tb.sv

//--- Makefile
# Verilator flow for the fall-through stream fifo

TOOL       := verilator
TOP        := fifo_fwft_tb
RTL_TOP    := fifo_fwft
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED

LINT_FLAGS := --lint-only --timing
FLAGS      := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
RUN_FLAGS  := +verilator+error+limit+1000

SOURCES    := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "sim: pass line missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
